/* async_fifo_defines.svh */
`ifndef ASYNC_FIFO_DEFINES_SVH
`define ASYNC_FIFO_DEFINES_SVH

// ************************************************************
// fifo sizing.
// ************************************************************

// word width in bits.
`define FIFO_DATA_WIDTH 8

// number of entries, a power of two.
`define FIFO_DEPTH 16

// log2 of the depth.
`define FIFO_ADDR_WIDTH 4

// ************************************************************
// flag thresholds.
// ************************************************************

// afull rises at this write-side occupancy.
`define FIFO_AFULL 14

// aempty is high at or below this read-side occupancy.
`define FIFO_AEMPTY 2

`endif

/* async_fifo_pkg.sv */
`default_nettype none

`include "async_fifo_defines.svh"

package async_fifo_pkg;

  // one stored word.
  typedef logic [`FIFO_DATA_WIDTH-1:0] data_t;

  // ram address.
  typedef logic [`FIFO_ADDR_WIDTH-1:0] addr_t;

  // pointer with wrap bit on top.
  // used for both the binary and the gray form.
  typedef logic [`FIFO_ADDR_WIDTH:0] ptr_t;

endpackage

`default_nettype wire

/* ptr_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module ptr_sync (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire async_fifo_pkg::ptr_t gray_in,
  output async_fifo_pkg::ptr_t     gray_sync,
  output async_fifo_pkg::ptr_t     bin_sync
);

  async_fifo_pkg::ptr_t sync_q1;
  async_fifo_pkg::ptr_t sync_q2;

  // two flops in the destination domain.
  always_ff @(posedge clk) begin
    if (rst) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= gray_in;
      sync_q2 <= sync_q1;
    end
  end

  assign gray_sync = sync_q2;

  // gray to binary, msb down.
  always_comb begin
    bin_sync[$bits(bin_sync)-1] = sync_q2[$bits(sync_q2)-1];
    for (int i = $bits(bin_sync) - 2; i >= 0; i--) begin
      bin_sync[i] = bin_sync[i+1] ^ sync_q2[i];
    end
  end

endmodule

`default_nettype wire

/* fifo_wr_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "async_fifo_defines.svh"

module fifo_wr_ctrl (
  input  wire logic                 wr_clk,
  input  wire logic                 rst,
  input  wire logic                 wr_en,
  input  wire async_fifo_pkg::ptr_t rd_gray,
  output logic                      wr_fire,
  output async_fifo_pkg::addr_t     wr_addr,
  output async_fifo_pkg::ptr_t      wr_gray,
  output logic                      full,
  output logic                      afull
);

  async_fifo_pkg::ptr_t wr_bin;
  async_fifo_pkg::ptr_t wr_bin_nxt;
  async_fifo_pkg::ptr_t wr_gray_nxt;
  async_fifo_pkg::ptr_t rd_bin_sync;
  async_fifo_pkg::ptr_t wr_occ_nxt;

  // read pointer into the write domain.
  ptr_sync u_rd_sync (
    .clk       (wr_clk),
    .rst       (rst),
    .gray_in   (rd_gray),
    .gray_sync (),
    .bin_sync  (rd_bin_sync)
  );

  // ************************************************************
  // accept and next pointer.
  // ************************************************************

  assign wr_fire     = wr_en & ~full;
  assign wr_bin_nxt  = wr_bin + async_fifo_pkg::ptr_t'(wr_fire);
  assign wr_gray_nxt = wr_bin_nxt ^ (wr_bin_nxt >> 1);

  // wraps modulo twice the depth.
  assign wr_occ_nxt  = wr_bin_nxt - rd_bin_sync;

  assign wr_addr = wr_bin[`FIFO_ADDR_WIDTH-1:0];

  // ************************************************************
  // registered pointers and flags.
  // ************************************************************

  always_ff @(posedge wr_clk) begin
    if (rst) begin
      wr_bin  <= '0;
      wr_gray <= '0;
      full    <= 1'b0;
      afull   <= 1'b0;
    end else begin
      wr_bin  <= wr_bin_nxt;
      wr_gray <= wr_gray_nxt;
      full    <= (wr_occ_nxt == async_fifo_pkg::ptr_t'(`FIFO_DEPTH));
      // conservative while the read pointer is in flight.
      afull   <= (wr_occ_nxt >= async_fifo_pkg::ptr_t'(`FIFO_AFULL));
    end
  end

endmodule

`default_nettype wire

/* fifo_rd_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "async_fifo_defines.svh"

module fifo_rd_ctrl (
  input  wire logic                 rd_clk,
  input  wire logic                 rst,
  input  wire logic                 rd_en,
  input  wire async_fifo_pkg::ptr_t wr_gray,
  output logic                      rd_fire,
  output async_fifo_pkg::addr_t     rd_addr,
  output async_fifo_pkg::ptr_t      rd_gray,
  output logic                      empty,
  output logic                      aempty
);

  async_fifo_pkg::ptr_t rd_bin;
  async_fifo_pkg::ptr_t rd_bin_nxt;
  async_fifo_pkg::ptr_t rd_gray_nxt;
  async_fifo_pkg::ptr_t wr_bin_sync;
  async_fifo_pkg::ptr_t rd_occ_nxt;

  // write pointer into the read domain.
  ptr_sync u_wr_sync (
    .clk       (rd_clk),
    .rst       (rst),
    .gray_in   (wr_gray),
    .gray_sync (),
    .bin_sync  (wr_bin_sync)
  );

  // ************************************************************
  // accept and next pointer.
  // ************************************************************

  assign rd_fire     = rd_en & ~empty;
  assign rd_bin_nxt  = rd_bin + async_fifo_pkg::ptr_t'(rd_fire);
  assign rd_gray_nxt = rd_bin_nxt ^ (rd_bin_nxt >> 1);

  // words the read side can see.
  assign rd_occ_nxt  = wr_bin_sync - rd_bin_nxt;

  assign rd_addr = rd_bin[`FIFO_ADDR_WIDTH-1:0];

  // ************************************************************
  // registered pointers and flags.
  // ************************************************************

  always_ff @(posedge rd_clk) begin
    if (rst) begin
      rd_bin  <= '0;
      rd_gray <= '0;
      empty   <= 1'b1;
      aempty  <= 1'b1;
    end else begin
      rd_bin  <= rd_bin_nxt;
      rd_gray <= rd_gray_nxt;
      empty   <= (rd_occ_nxt == '0);
      // lags new writes by the sync delay.
      aempty  <= (rd_occ_nxt <= async_fifo_pkg::ptr_t'(`FIFO_AEMPTY));
    end
  end

endmodule

`default_nettype wire

/* dualport_ram_async.sv */
`timescale 1ns/1ps
`default_nettype none

`include "async_fifo_defines.svh"

module dualport_ram_async (
  input  wire logic                  wr_clk,
  input  wire logic                  wr_fire,
  input  wire async_fifo_pkg::addr_t wr_addr,
  input  wire async_fifo_pkg::data_t wr_data,
  input  wire logic                  rd_clk,
  input  wire logic                  rst,
  input  wire logic                  rd_fire,
  input  wire async_fifo_pkg::addr_t rd_addr,
  output async_fifo_pkg::data_t      rd_data
);

  async_fifo_pkg::data_t mem [`FIFO_DEPTH];

  // write port.
  always_ff @(posedge wr_clk) begin
    if (wr_fire) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read, holds between reads.
  always_ff @(posedge rd_clk) begin
    if (rst) begin
      rd_data <= '0;
    end else if (rd_fire) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

/* async_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module async_fifo (
  input  wire logic                  wr_clk,
  input  wire logic                  rd_clk,
  input  wire logic                  rst,
  input  wire logic                  wr_en,
  input  wire logic                  rd_en,
  input  wire async_fifo_pkg::data_t wr_data,
  output async_fifo_pkg::data_t      rd_data,
  output logic                       full,
  output logic                       afull,
  output logic                       empty,
  output logic                       aempty
);

  logic                  wr_fire;
  logic                  rd_fire;
  async_fifo_pkg::addr_t wr_addr;
  async_fifo_pkg::addr_t rd_addr;
  async_fifo_pkg::ptr_t  wr_gray;
  async_fifo_pkg::ptr_t  rd_gray;

  // ************************************************************
  // write domain.
  // ************************************************************

  fifo_wr_ctrl u_wr_ctrl (
    .wr_clk  (wr_clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .rd_gray (rd_gray),
    .wr_fire (wr_fire),
    .wr_addr (wr_addr),
    .wr_gray (wr_gray),
    .full    (full),
    .afull   (afull)
  );

  // ************************************************************
  // read domain.
  // ************************************************************

  fifo_rd_ctrl u_rd_ctrl (
    .rd_clk  (rd_clk),
    .rst     (rst),
    .rd_en   (rd_en),
    .wr_gray (wr_gray),
    .rd_fire (rd_fire),
    .rd_addr (rd_addr),
    .rd_gray (rd_gray),
    .empty   (empty),
    .aempty  (aempty)
  );

  // storage between the two domains.
  dualport_ram_async u_ram (
    .wr_clk  (wr_clk),
    .wr_fire (wr_fire),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_clk  (rd_clk),
    .rst     (rst),
    .rd_fire (rd_fire),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

`default_nettype wire

/* async_fifo_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module async_fifo_assertions (
  input wire logic                 wr_clk,
  input wire logic                 rd_clk,
  input wire logic                 rst,
  input wire async_fifo_pkg::ptr_t wr_gray,
  input wire async_fifo_pkg::ptr_t rd_gray,
  input wire logic                 full,
  input wire logic                 afull,
  input wire logic                 empty,
  input wire logic                 aempty
);

  int assert_errors = 0;

  // gray pointers move by one bit or stay put.
  wr_gray_step: assert property (
    @(posedge wr_clk) disable iff (rst) $onehot0(wr_gray ^ $past(wr_gray))
  ) else begin
    assert_errors++;
    $error("wr_gray changed by more than one bit in one wr_clk cycle");
  end

  rd_gray_step: assert property (
    @(posedge rd_clk) disable iff (rst) $onehot0(rd_gray ^ $past(rd_gray))
  ) else begin
    assert_errors++;
    $error("rd_gray changed by more than one bit in one rd_clk cycle");
  end

  // flags still hold their reset values right after rst falls.
  wr_flags_after_rst: assert property (
    @(posedge wr_clk) $fell(rst) |-> (!full && !afull)
  ) else begin
    assert_errors++;
    $error("full or afull high in the cycle after reset");
  end

  rd_flags_after_rst: assert property (
    @(posedge rd_clk) $fell(rst) |-> (empty && aempty)
  ) else begin
    assert_errors++;
    $error("empty or aempty low in the cycle after reset");
  end

endmodule

bind async_fifo async_fifo_assertions u_assert (
  .wr_clk  (wr_clk),
  .rd_clk  (rd_clk),
  .rst     (rst),
  .wr_gray (wr_gray),
  .rd_gray (rd_gray),
  .full    (full),
  .afull   (afull),
  .empty   (empty),
  .aempty  (aempty)
);

`default_nettype wire

/* async_fifo_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "async_fifo_defines.svh"

module async_fifo_checker (
  input  wire logic                  wr_clk,
  input  wire logic                  rd_clk,
  input  wire logic                  rst,
  input  wire logic                  wr_en,
  input  wire logic                  rd_en,
  input  wire async_fifo_pkg::data_t rd_data,
  input  wire logic                  full,
  input  wire logic                  empty,
  output int                         wr_count,
  output int                         rd_count
);

  int data_errors = 0;
  int overflow_errors = 0;
  int check_errors = 0;

  async_fifo_pkg::data_t rd_expected;

  // odd multiplier walks every byte value; high bits fold back in.
  function automatic async_fifo_pkg::data_t data_pattern(input int n);
    return async_fifo_pkg::data_t'(n * 37 + 11) ^ async_fifo_pkg::data_t'(n >> 8);
  endfunction

  task automatic check_bit(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      check_errors++;
      $display("ERROR at %0t ns: %s expected %0b got %0b", $time, what, expected, actual);
    end
  endtask

  task automatic check_count(input string what, input int expected, input int actual);
    if (actual != expected) begin
      check_errors++;
      $display("ERROR at %0t ns: %s expected %0d got %0d", $time, what, expected, actual);
    end
  endtask

  // ************************************************************
  // write side.
  // ************************************************************

  always @(posedge wr_clk) begin
    if (rst) begin
      wr_count <= 0;
    end else if (wr_en && !full) begin
      if (wr_count - rd_count >= `FIFO_DEPTH) begin
        overflow_errors++;
        $display("ERROR at %0t ns: write accepted with %0d words stored",
                 $time, wr_count - rd_count);
      end
      wr_count <= wr_count + 1;
    end
  end

  // ************************************************************
  // read side.
  // ************************************************************

  always @(posedge rd_clk) begin
    if (rst) begin
      rd_count    <= 0;
      rd_expected <= '0;
    end else begin
      // word of the last accept, held until the next one.
      if (rd_data !== rd_expected) begin
        data_errors++;
        $display("ERROR at %0t ns: rd_data after %0d reads expected %02h got %02h",
                 $time, rd_count, rd_expected, rd_data);
      end
      if (rd_en && !empty) begin
        if (rd_count >= wr_count) begin
          data_errors++;
          $display("ERROR at %0t ns: read %0d accepted with %0d words written",
                   $time, rd_count, wr_count);
        end
        rd_expected <= data_pattern(rd_count);
        rd_count    <= rd_count + 1;
      end
    end
  end

endmodule

`default_nettype wire

/* tb_async_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "async_fifo_defines.svh"

module tb_async_fifo;

  // planned phases take about 450 wr_clk cycles.
  localparam int max_cycles = 4000;

  logic                  wr_clk = 1'b0;
  logic                  rd_clk = 1'b0;
  logic                  rst;
  logic                  wr_en;
  logic                  rd_en;
  async_fifo_pkg::data_t wr_data;
  async_fifo_pkg::data_t rd_data;
  logic                  full;
  logic                  afull;
  logic                  empty;
  logic                  aempty;
  int                    wr_count;
  int                    rd_count;
  int                    wr_sent;
  int                    quiet;
  int                    cycles = 0;
  integer                seed;
  logic                  wr_done;

  always #20 wr_clk = ~wr_clk;
  always #28 rd_clk = ~rd_clk;

  async_fifo uut (
    .wr_clk  (wr_clk),
    .rd_clk  (rd_clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .rd_en   (rd_en),
    .wr_data (wr_data),
    .rd_data (rd_data),
    .full    (full),
    .afull   (afull),
    .empty   (empty),
    .aempty  (aempty)
  );

  async_fifo_checker chk (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .rst      (rst),
    .wr_en    (wr_en),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .empty    (empty),
    .wr_count (wr_count),
    .rd_count (rd_count)
  );

  always @(posedge wr_clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: run did not finish within %0d wr_clk cycles", max_cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // one wr_clk step; wr_data always carries the next sequence number.
  task automatic write_step(input logic en);
    @(posedge wr_clk);
    if (wr_en && !full) begin
      wr_sent++;
    end
    wr_en   <= en;
    wr_data <= chk.data_pattern(wr_sent);
  endtask

  initial begin
    seed    = 32'h67ae_2cd9;
    rst     = 1'b1;
    wr_en   = 1'b0;
    rd_en   = 1'b0;
    wr_data = '0;
    wr_sent = 0;
    wr_done = 1'b0;
    repeat (8) @(posedge wr_clk);
    rst <= 1'b0;

    // ************************************************************
    // reset state, then fill with reads held off.
    // ************************************************************
    @(negedge wr_clk);
    chk.check_bit("full after reset", 1'b0, full);
    chk.check_bit("afull after reset", 1'b0, afull);
    chk.check_bit("empty after reset", 1'b1, empty);
    chk.check_bit("aempty after reset", 1'b1, aempty);
    for (int i = 0; i < 24; i++) begin
      write_step(1'b1);
      @(negedge wr_clk);
      chk.check_bit("full during fill", wr_count >= `FIFO_DEPTH, full);
      chk.check_bit("afull during fill", wr_count >= `FIFO_AFULL, afull);
    end
    write_step(1'b0);
    chk.check_count("writes accepted in fill", `FIFO_DEPTH, wr_count);

    // drain with the write pointer long settled.
    @(posedge rd_clk);
    rd_en <= 1'b1;
    for (int i = 0; i < 22; i++) begin
      @(negedge rd_clk);
      chk.check_bit("empty during drain", rd_count >= `FIFO_DEPTH, empty);
      chk.check_bit("aempty during drain", `FIFO_DEPTH - rd_count <= `FIFO_AEMPTY, aempty);
    end
    @(posedge rd_clk);
    rd_en <= 1'b0;
    chk.check_count("reads accepted in drain", `FIFO_DEPTH, rd_count);

    // ************************************************************
    // random traffic on both sides, then final drain.
    // ************************************************************
    fork
      begin
        for (int i = 0; i < 300; i++) begin
          write_step(1'($random(seed)));
        end
        wr_done = 1'b1;
      end
      begin
        while (!wr_done) begin
          @(posedge rd_clk);
          rd_en <= 1'($random(seed));
        end
      end
    join
    write_step(1'b0);
    @(posedge rd_clk);
    rd_en <= 1'b1;
    quiet = 0;
    while (quiet < 10) begin
      @(negedge rd_clk);
      if (empty) begin
        quiet++;
      end else begin
        quiet = 0;
      end
    end
    @(posedge rd_clk);
    rd_en <= 1'b0;
    chk.check_count("reads against writes", wr_count, rd_count);

    $display({"closing: data errors %0d, overflow errors %0d, check errors %0d,",
              " assertion errors %0d"},
             chk.data_errors, chk.overflow_errors, chk.check_errors,
             uut.u_assert.assert_errors);
    if (chk.data_errors + chk.overflow_errors + chk.check_errors
        + uut.u_assert.assert_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* async_fifo.f */
+incdir+.
async_fifo_pkg.sv
ptr_sync.sv
fifo_wr_ctrl.sv
fifo_rd_ctrl.sv
dualport_ram_async.sv
async_fifo.sv
async_fifo_assertions.sv
async_fifo_checker.sv
tb_async_fifo.sv

/* run_sim.sh */
#!/bin/sh
# build with verilator, run, then judge the log.
rm -rf obj_dir sim.log
verilator --binary --assert --top-module tb_async_fifo -f async_fifo.f -o tb_async_fifo \
  || { echo "verilator build failed"; exit 1; }
./obj_dir/tb_async_fifo > sim.log 2>&1 \
  || echo "simulation ended with an error status" >> sim.log
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "no pass line in the log"; exit 1; }
echo "simulation passed"
